// File: verilog/nocFlitPkg.sv
`default_nettype none

package nocFlitPkg;

  parameter int FlitWidth    = 16;
  parameter int KindWidth    = 3;
  parameter int PayloadWidth = 12;

  // kind field occupies the top bits.
  // bit 12 is reserved and payload is the low bits.
  parameter int KindMsb = FlitWidth - 1;
  parameter int KindLsb = FlitWidth - KindWidth;

  // header code matches the legacy router.
  typedef enum logic [KindWidth-1:0] {
    kindIdle   = 3'd0,
    kindHeader = 3'd1,
    kindBody   = 3'd2,
    kindTail   = 3'd4
  } flitKind_t;

endpackage

`default_nettype wire

// File: verilog/nocArbPkg.sv
`default_nettype none

package nocArbPkg;

  parameter int NumPorts = 5;

  // port number is also the rotation order.
  typedef enum logic [2:0] {
    portLocal = 3'd0,
    portNorth = 3'd1,
    portEast  = 3'd2,
    portWest  = 3'd3,
    portSouth = 3'd4
  } port_t;

  // each grant state is its port number plus one.
  typedef enum logic [2:0] {
    stIdle   = 3'd0,
    stGrantL = 3'd1,
    stGrantN = 3'd2,
    stGrantE = 3'd3,
    stGrantW = 3'd4,
    stGrantS = 3'd5
  } arbState_t;

endpackage

`default_nettype wire

// File: verilog/inputStage.sv
`default_nettype none

module inputStage #(
  parameter int LengthWidth = 12
) (
  input  wire                              clk,
  input  wire                              rst,
  input  wire  [nocFlitPkg::FlitWidth-1:0] flitL,
  input  wire  [nocFlitPkg::FlitWidth-1:0] flitN,
  input  wire  [nocFlitPkg::FlitWidth-1:0] flitE,
  input  wire  [nocFlitPkg::FlitWidth-1:0] flitW,
  input  wire  [nocFlitPkg::FlitWidth-1:0] flitS,
  input  wire                              reqL,
  input  wire                              reqN,
  input  wire                              reqE,
  input  wire                              reqW,
  input  wire                              reqS,
  output logic [nocFlitPkg::FlitWidth-1:0] stFlitL,
  output logic [nocFlitPkg::FlitWidth-1:0] stFlitN,
  output logic [nocFlitPkg::FlitWidth-1:0] stFlitE,
  output logic [nocFlitPkg::FlitWidth-1:0] stFlitW,
  output logic [nocFlitPkg::FlitWidth-1:0] stFlitS,
  output logic                             stReqL,
  output logic                             stReqN,
  output logic                             stReqE,
  output logic                             stReqW,
  output logic                             stReqS,
  output logic                             headerSeenL,
  output logic                             headerSeenN,
  output logic                             headerSeenE,
  output logic                             headerSeenW,
  output logic                             headerSeenS,
  output logic [LengthWidth-1:0]           hdrLengthL,
  output logic [LengthWidth-1:0]           hdrLengthN,
  output logic [LengthWidth-1:0]           hdrLengthE,
  output logic [LengthWidth-1:0]           hdrLengthW,
  output logic [LengthWidth-1:0]           hdrLengthS
);

  import nocFlitPkg::*;
  import nocArbPkg::*;

  logic [FlitWidth-1:0]   flitIn [NumPorts];
  logic [NumPorts-1:0]    reqIn;
  flitKind_t              kindIn [NumPorts];
  logic [NumPorts-1:0]    isHeader;
  logic [FlitWidth-1:0]   flitQ [NumPorts];
  logic [NumPorts-1:0]    reqQ;
  logic [NumPorts-1:0]    headerQ;
  logic [LengthWidth-1:0] lengthQ [NumPorts];

  // time limit is taken from the payload field.
  if (LengthWidth > PayloadWidth)
  begin : gLengthCheck
    $error("LengthWidth is wider than the flit payload");
  end

  assign flitIn = '{flitL, flitN, flitE, flitW, flitS};
  assign reqIn  = {reqS, reqW, reqE, reqN, reqL};

  always_comb
  begin
    for (int i = 0; i < NumPorts; i++)
    begin
      kindIn[i]   = flitKind_t'(flitIn[i][KindMsb:KindLsb]);
      isHeader[i] = reqIn[i] && (kindIn[i] == kindHeader);
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      reqQ    <= '0;
      headerQ <= '0;
    end
    else
    begin
      reqQ    <= reqIn;
      headerQ <= isHeader;
    end
  end

  always_ff @(posedge clk)
  begin
    for (int i = 0; i < NumPorts; i++)
    begin
      flitQ[i] <= flitIn[i];
      if (isHeader[i])
        lengthQ[i] <= flitIn[i][LengthWidth-1:0];
    end
  end

  assign {stReqS, stReqW, stReqE, stReqN, stReqL} = reqQ;
  assign {headerSeenS, headerSeenW, headerSeenE, headerSeenN, headerSeenL} = headerQ;

  assign stFlitL    = flitQ[portLocal];
  assign stFlitN    = flitQ[portNorth];
  assign stFlitE    = flitQ[portEast];
  assign stFlitW    = flitQ[portWest];
  assign stFlitS    = flitQ[portSouth];
  assign hdrLengthL = lengthQ[portLocal];
  assign hdrLengthN = lengthQ[portNorth];
  assign hdrLengthE = lengthQ[portEast];
  assign hdrLengthW = lengthQ[portWest];
  assign hdrLengthS = lengthQ[portSouth];

endmodule

`default_nettype wire

// File: verilog/portTimer.sv
`default_nettype none

module portTimer #(
  parameter int LengthWidth = 12
) (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   headerSeen,
  input  wire [LengthWidth-1:0] hdrLength,
  input  wire                   run,
  output logic                  timesUp
);

  logic [LengthWidth-1:0] limit;
  logic [LengthWidth-1:0] count;

  ////////////////////////////////////////////////////////////
  // limit and hold counter
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      // a new header replaces the limit.
      if (headerSeen)
        limit <= hdrLength;
      // count restarts whenever the port is not being held.
      if (run)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  assign timesUp = (count == limit);

endmodule

`default_nettype wire

// File: verilog/grantArbiter.sv
`default_nettype none

module grantArbiter (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  stReqL,
  input  wire                  stReqN,
  input  wire                  stReqE,
  input  wire                  stReqW,
  input  wire                  stReqS,
  input  wire                  timesUpL,
  input  wire                  timesUpN,
  input  wire                  timesUpE,
  input  wire                  timesUpW,
  input  wire                  timesUpS,
  output nocArbPkg::arbState_t nextState,
  output nocArbPkg::port_t     grantPort,
  output logic                 runL,
  output logic                 runN,
  output logic                 runE,
  output logic                 runW,
  output logic                 runS
);

  import nocArbPkg::*;

  arbState_t           state;
  port_t               holder;
  logic                holderValid;
  port_t               nextPort;
  logic [NumPorts-1:0] req;
  logic [NumPorts-1:0] timesUp;
  logic [NumPorts-1:0] run;

  assign req     = {stReqS, stReqW, stReqE, stReqN, stReqL};
  assign timesUp = {timesUpS, timesUpW, timesUpE, timesUpN, timesUpL};

  assign {runS, runW, runE, runN, runL} = run;

  function automatic arbState_t stateFor(input port_t p);
    return arbState_t'(p + 3'd1);
  endfunction

  // current holder from the state code.
  always_comb
  begin
    holderValid = (state != stIdle) && (state <= stGrantS);
    holder      = port_t'(state - 3'd1);
  end

  ////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    int idx;
    idx       = 0;
    nextState = stIdle;
    nextPort  = grantPort;
    run       = '0;
    if (!holderValid)
    begin
      // fixed priority out of idle, local first.
      for (int i = NumPorts - 1; i >= 0; i--)
      begin
        if (req[i])
        begin
          nextPort  = port_t'(i);
          nextState = stateFor(port_t'(i));
        end
      end
    end
    else if (req[holder] && !timesUp[holder])
    begin
      run[holder] = 1'b1;
      nextPort    = holder;
      nextState   = state;
    end
    else
    begin
      // rotate from the port after the holder.
      // the holder itself is checked last.
      for (int k = NumPorts; k >= 1; k--)
      begin
        idx = int'(holder) + k;
        if (idx >= NumPorts)
          idx = idx - NumPorts;
        if (req[idx])
        begin
          nextPort  = port_t'(idx);
          nextState = stateFor(port_t'(idx));
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // state and grant registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state     <= stIdle;
      grantPort <= portLocal;
    end
    else
    begin
      state     <= nextState;
      grantPort <= nextPort;
    end
  end

endmodule

`default_nettype wire

// File: verilog/outputMux.sv
`default_nettype none

module outputMux (
  input  wire                              clk,
  input  wire                              rst,
  input  wire  nocArbPkg::arbState_t       nextState,
  input  wire  [nocFlitPkg::FlitWidth-1:0] stFlitL,
  input  wire  [nocFlitPkg::FlitWidth-1:0] stFlitN,
  input  wire  [nocFlitPkg::FlitWidth-1:0] stFlitE,
  input  wire  [nocFlitPkg::FlitWidth-1:0] stFlitW,
  input  wire  [nocFlitPkg::FlitWidth-1:0] stFlitS,
  output logic [nocFlitPkg::FlitWidth-1:0] outFlit,
  output logic                             outValid
);

  import nocFlitPkg::*;
  import nocArbPkg::*;

  logic [FlitWidth-1:0] flitIn [NumPorts];
  logic [NumPorts-1:0]  sel;
  logic [FlitWidth-1:0] chosen;

  assign flitIn = '{stFlitL, stFlitN, stFlitE, stFlitW, stFlitS};

  // one-hot select from the grant state.
  // no bit is set in idle so the flit goes to zero.
  always_comb
  begin
    chosen = '0;
    for (int i = 0; i < NumPorts; i++)
    begin
      sel[i] = (nextState == arbState_t'(i + 1));
      chosen = chosen | (flitIn[i] & {FlitWidth{sel[i]}});
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outFlit  <= '0;
      outValid <= 1'b0;
    end
    else
    begin
      outFlit  <= chosen;
      outValid <= (nextState != stIdle);
    end
  end

endmodule

`default_nettype wire

// File: verilog/routerOutputPort.sv
`default_nettype none

module routerOutputPort #(
  parameter int LengthWidth = 12
) (
  input  wire                              clk,
  input  wire                              rst,
  input  wire  [nocFlitPkg::FlitWidth-1:0] flitL,
  input  wire  [nocFlitPkg::FlitWidth-1:0] flitN,
  input  wire  [nocFlitPkg::FlitWidth-1:0] flitE,
  input  wire  [nocFlitPkg::FlitWidth-1:0] flitW,
  input  wire  [nocFlitPkg::FlitWidth-1:0] flitS,
  input  wire                              reqL,
  input  wire                              reqN,
  input  wire                              reqE,
  input  wire                              reqW,
  input  wire                              reqS,
  output logic [nocFlitPkg::FlitWidth-1:0] outFlit,
  output logic                             outValid,
  output nocArbPkg::port_t                 grantPort
);

  import nocFlitPkg::*;
  import nocArbPkg::*;

  wire [FlitWidth-1:0]   stFlitL;
  wire [FlitWidth-1:0]   stFlitN;
  wire [FlitWidth-1:0]   stFlitE;
  wire [FlitWidth-1:0]   stFlitW;
  wire [FlitWidth-1:0]   stFlitS;
  wire [NumPorts-1:0]    stReq;
  wire [NumPorts-1:0]    headerSeen;
  wire [LengthWidth-1:0] hdrLength [NumPorts];
  wire [NumPorts-1:0]    run;
  wire [NumPorts-1:0]    timesUp;
  wire arbState_t        nextState;

  inputStage #(
    .LengthWidth(LengthWidth)
  ) u_inputStage (
    .*,
    .stReqL     (stReq[portLocal]),
    .stReqN     (stReq[portNorth]),
    .stReqE     (stReq[portEast]),
    .stReqW     (stReq[portWest]),
    .stReqS     (stReq[portSouth]),
    .headerSeenL(headerSeen[portLocal]),
    .headerSeenN(headerSeen[portNorth]),
    .headerSeenE(headerSeen[portEast]),
    .headerSeenW(headerSeen[portWest]),
    .headerSeenS(headerSeen[portSouth]),
    .hdrLengthL (hdrLength[portLocal]),
    .hdrLengthN (hdrLength[portNorth]),
    .hdrLengthE (hdrLength[portEast]),
    .hdrLengthW (hdrLength[portWest]),
    .hdrLengthS (hdrLength[portSouth])
  );

  // one hold timer per input port.
  for (genvar i = 0; i < NumPorts; i++)
  begin : gTimer
    portTimer #(
      .LengthWidth(LengthWidth)
    ) u_portTimer (
      .clk       (clk),
      .rst       (rst),
      .headerSeen(headerSeen[i]),
      .hdrLength (hdrLength[i]),
      .run       (run[i]),
      .timesUp   (timesUp[i])
    );
  end

  grantArbiter u_grantArbiter (
    .*,
    .stReqL  (stReq[portLocal]),
    .stReqN  (stReq[portNorth]),
    .stReqE  (stReq[portEast]),
    .stReqW  (stReq[portWest]),
    .stReqS  (stReq[portSouth]),
    .timesUpL(timesUp[portLocal]),
    .timesUpN(timesUp[portNorth]),
    .timesUpE(timesUp[portEast]),
    .timesUpW(timesUp[portWest]),
    .timesUpS(timesUp[portSouth]),
    .runL    (run[portLocal]),
    .runN    (run[portNorth]),
    .runE    (run[portEast]),
    .runW    (run[portWest]),
    .runS    (run[portSouth])
  );

  outputMux u_outputMux (
    .*
  );

endmodule

`default_nettype wire

// File: sim/grantArbiter_checker.sv
`default_nettype none

module grantArbiter_checker (
  input wire                       clk,
  input wire                       rst,
  input wire nocArbPkg::arbState_t state,
  input wire                       runL,
  input wire                       runN,
  input wire                       runE,
  input wire                       runW,
  input wire                       runS
);

  timeunit 1ns;
  timeprecision 1ps;

  import nocArbPkg::*;

  logic [NumPorts-1:0] run;
  logic [NumPorts-1:0] holderMask;

  assign run = {runS, runW, runE, runN, runL};

  // the port that the current grant state stands for.
  always_comb
  begin
    case (state)
      stGrantL: holderMask = 5'b00001;
      stGrantN: holderMask = 5'b00010;
      stGrantE: holderMask = 5'b00100;
      stGrantW: holderMask = 5'b01000;
      stGrantS: holderMask = 5'b10000;
      default:  holderMask = 5'b00000;
    endcase
  end

  oneRunLevel: assert property (@(posedge clk) disable iff (rst) $onehot0(run))
    else $error("more than one timer run level is high");

  runOnlyForHolder: assert property (@(posedge clk) disable iff (rst) (run & ~holderMask) == '0)
    else $error("a timer runs for a port that does not hold the grant");

  idleAfterReset: assert property (@(posedge clk) rst |=> state == stIdle)
    else $error("arbiter state is not idle after reset");

endmodule

`default_nettype wire

// File: sim/routerOutputPortTb.sv
`default_nettype none

module routerOutputPortTb;

  timeunit 1ns;
  timeprecision 1ps;

  import nocFlitPkg::*;
  import nocArbPkg::*;

  localparam int ClkPeriod    = 40;
  localparam int NoGrant      = -1;
  localparam int MarginCycles = 20;
  // reset plus the steps and drain cycles of each test in order.
  localparam int TestCycles   = 11 + 4 + 9 + 7 + 14 + 7 + 6;

  localparam logic [NumPorts-1:0] ReqL = 5'b00001;
  localparam logic [NumPorts-1:0] ReqN = 5'b00010;
  localparam logic [NumPorts-1:0] ReqE = 5'b00100;
  localparam logic [NumPorts-1:0] ReqW = 5'b01000;
  localparam logic [NumPorts-1:0] ReqS = 5'b10000;

  logic                 clk;
  logic                 rst;
  logic [FlitWidth-1:0] flitIn [NumPorts];
  logic [NumPorts-1:0]  reqIn;
  logic [FlitWidth-1:0] outFlit;
  logic                 outValid;
  port_t                grantPort;

  logic [31:0]          rngState;
  int                   errorCount;
  int                   checkCount;
  string                testName;
  int                   expPortQ [$];
  logic [FlitWidth-1:0] expFlitQ [$];

  routerOutputPort #(
    .LengthWidth(12)
  ) u_routerOutputPort (
    .clk      (clk),
    .rst      (rst),
    .flitL    (flitIn[0]),
    .flitN    (flitIn[1]),
    .flitE    (flitIn[2]),
    .flitW    (flitIn[3]),
    .flitS    (flitIn[4]),
    .reqL     (reqIn[0]),
    .reqN     (reqIn[1]),
    .reqE     (reqIn[2]),
    .reqW     (reqIn[3]),
    .reqS     (reqIn[4]),
    .outFlit  (outFlit),
    .outValid (outValid),
    .grantPort(grantPort)
  );

  bind grantArbiter grantArbiter_checker u_grantArbiterChecker (
    .clk  (clk),
    .rst  (rst),
    .state(state),
    .runL (runL),
    .runN (runN),
    .runE (runE),
    .runW (runW),
    .runS (runS)
  );

  initial
  begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  initial
  begin
    #(TestCycles * ClkPeriod + MarginCycles * ClkPeriod);
    $display("timeout: the tests did not finish within %0d cycles", TestCycles + MarginCycles);
    $display("Regression failed");
    $finish;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // kind in the top three bits, bit 12 left at zero.
  function automatic logic [FlitWidth-1:0] makeFlit(input flitKind_t kind,
                                                    input logic [PayloadWidth-1:0] payload);
    return {kind, 1'b0, payload};
  endfunction

  task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
    checkCount++;
    if (actual !== expected)
    begin
      errorCount++;
      $display("mismatch at %0t ns in %s test: %s is %0h, expected %0h",
               $time, testName, what, actual, expected);
    end
  endtask

  task automatic checkOutput();
    int                   expPort;
    logic [FlitWidth-1:0] expFlit;
    expPort = expPortQ.pop_front();
    expFlit = expFlitQ.pop_front();
    checkValue(32'(outValid), (expPort >= 0) ? 32'd1 : 32'd0, "outValid");
    checkValue(32'(outFlit), 32'(expFlit), "outFlit");
    if (expPort >= 0)
      checkValue(32'(grantPort), 32'(expPort), "grantPort");
  endtask

  // one input cycle. the expected grant belongs to the data driven now
  // and is checked two edges later.
  task automatic driveStep(input logic [NumPorts-1:0] reqs, input logic [NumPorts-1:0] hdrs,
                           input logic [PayloadWidth-1:0] len, input int expPort);
    logic [FlitWidth-1:0] f [NumPorts];
    for (int p = 0; p < NumPorts; p++)
    begin
      rngState = xorshift(rngState);
      if (hdrs[p])
        f[p] = makeFlit(kindHeader, len);
      else
        f[p] = makeFlit(kindBody, rngState[PayloadWidth-1:0]);
    end
    @(posedge clk);
    for (int p = 0; p < NumPorts; p++)
      flitIn[p] <= f[p];
    reqIn <= reqs;
    expPortQ.push_back(expPort);
    expFlitQ.push_back((expPort >= 0) ? f[expPort] : '0);
    @(negedge clk);
    while (expPortQ.size() > 2)
      checkOutput();
  endtask

  // the last step reaches the output two edges after it was driven.
  task automatic drainPipeline();
    for (int e = 2; e > 0; e--)
    begin
      @(posedge clk);
      reqIn <= '0;
      @(negedge clk);
      if (expPortQ.size() >= e)
        checkOutput();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////

  task automatic resetTest();
    testName = "reset";
    checkValue(32'(outValid), 32'd0, "outValid after reset");
    checkValue(32'(grantPort), 32'(portLocal), "grantPort after reset");
    driveStep('0, '0, '0, NoGrant);
    driveStep('0, '0, '0, NoGrant);
    drainPipeline();
  endtask

  task automatic singlePortTest();
    testName = "single port";
    driveStep(ReqN, ReqN, 12'd20, portNorth);
    repeat (6) driveStep(ReqN, '0, '0, portNorth);
    drainPipeline();
  endtask

  task automatic idlePriorityTest();
    testName = "idle priority";
    driveStep(ReqL | ReqN | ReqE | ReqW | ReqS, '0, '0, portLocal);
    drainPipeline();
    // south alone must not fall back to idle.
    driveStep(ReqS, '0, '0, portSouth);
    driveStep(ReqS, '0, '0, portSouth);
    drainPipeline();
  endtask

  task automatic timeoutRotationTest();
    logic [NumPorts-1:0] reqs;
    testName = "timeout rotation";
    reqs = ReqL | ReqN | ReqE;
    // limit 3 gives each holder four output cycles.
    driveStep(reqs, reqs, 12'd3, portLocal);
    repeat (3) driveStep(reqs, '0, '0, portLocal);
    repeat (4) driveStep(reqs, '0, '0, portNorth);
    repeat (4) driveStep(reqs, '0, '0, portEast);
    drainPipeline();
  endtask

  task automatic releaseRotationTest();
    testName = "release rotation";
    driveStep(ReqW, ReqW, 12'd10, portWest);
    driveStep(ReqW | ReqN | ReqS, '0, '0, portWest);
    // west lets go early, south comes first after west.
    driveStep(ReqN | ReqS, '0, '0, portSouth);
    driveStep(ReqN | ReqE, '0, '0, portNorth);
    driveStep(ReqN | ReqE, '0, '0, portNorth);
    drainPipeline();
  endtask

  task automatic dropAllTest();
    testName = "all requests dropped";
    driveStep(ReqE, '0, '0, portEast);
    driveStep(ReqE, '0, '0, portEast);
    driveStep('0, '0, '0, NoGrant);
    driveStep('0, '0, '0, NoGrant);
    drainPipeline();
  endtask

  initial
  begin
    rst        = 1'b1;
    reqIn      = '0;
    rngState   = 32'h5e61581d;
    errorCount = 0;
    checkCount = 0;
    testName   = "none";
    for (int p = 0; p < NumPorts; p++)
      flitIn[p] = '0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    resetTest();
    singlePortTest();
    idlePriorityTest();
    timeoutRotationTest();
    releaseRotationTest();
    dropAllTest();
    $display("%0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
verilog/nocFlitPkg.sv
verilog/nocArbPkg.sv
verilog/inputStage.sv
verilog/portTimer.sv
verilog/grantArbiter.sv
verilog/outputMux.sv
verilog/routerOutputPort.sv
sim/grantArbiter_checker.sv
sim/routerOutputPortTb.sv

// File: Makefile
TOP := routerOutputPortTb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir
